// ==== common/i3c_target_pkg.sv ====
// I3C target shared definitions
package i3c_target_pkg;

  // Bus conditions seen by the monitor, one-cycle pulses
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  // State machine to flow block
  // addr and rnw qualify xfer_start only
  typedef struct packed {
    logic       xfer_start;
    logic       xfer_stop;
    logic [6:0] addr;
    logic       rnw;
    logic       rx_valid;
    logic [7:0] rx_byte;
  } byte_stream_t;

  // One per write transfer addressed to this target
  typedef struct packed {
    logic [6:0] addr;
    logic [7:0] byte_count;
    logic       dyn;
  } rx_desc_t;

  localparam logic [6:0] BroadcastAddr = 7'h7E;

  // Broadcast code, next byte carries the new address in [7:1]
  localparam logic [7:0] CccSetDynAddr = 8'h87;

  // Sent on reads with nothing queued
  localparam logic [7:0] ReadFillByte = 8'hFF;

endpackage

// ==== hw/bus_monitor.sv ====
// I3C bus condition monitor
`timescale 1ns/100ps

module bus_monitor (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       enable_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output i3c_target_pkg::bus_event_t event_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_q;
  logic       sda_q;
  logic       scl_s;
  logic       sda_s;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      event_o    <= '0;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_q      <= scl_s;
      sda_q      <= sda_s;

      // SDA edges count only while SCL stays high
      event_o.start    <= enable_i && scl_s && scl_q && sda_q && !sda_s;
      event_o.stop     <= enable_i && scl_s && scl_q && !sda_q && sda_s;
      event_o.scl_rise <= enable_i && scl_s && !scl_q;
      event_o.scl_fall <= enable_i && !scl_s && scl_q;
      event_o.sda      <= sda_s;
    end
  end

endmodule

// ==== target_fsm/target_fsm.sv ====
// I3C target bit-level state machine
`timescale 1ns/100ps

module target_fsm (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  i3c_target_pkg::bus_event_t   event_i,
  output logic                         sda_o,
  output logic [6:0]                   addr_o,
  output logic                         addr_valid_o,
  input  logic                         match_i,
  input  logic                         is_dyn_i,
  output logic                         dyn_load_o,
  output logic [6:0]                   dyn_addr_o,
  output i3c_target_pkg::byte_stream_t stream_o,
  input  logic                         rx_full_i,
  input  logic                         tx_valid_i,
  input  logic [7:0]                   tx_byte_i,
  output logic                         tx_take_o
);
  import i3c_target_pkg::*;

  typedef enum logic [3:0] {
    StIdle,
    StAddr,
    StAddrAck,
    StWrData,
    StDataAck,
    StRdData,
    StCtrlAck,
    StBcastCmd,
    StIgnore
  } state_e;

  state_e     state_q;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       sda_q;
  logic       rnw_q;
  logic       bcast_q;
  logic       ack_q;
  logic       active_q;
  logic       cmd_seen_q;
  logic       setda_q;

  logic       rise;
  logic       fall;
  logic       byte_done;
  logic       ack_fall;
  logic       rx_state;
  logic       bcast_hit;
  logic       load_tx;
  logic [7:0] rx_byte;
  logic [7:0] tx_next;

  assign rise      = event_i.scl_rise;
  assign fall      = event_i.scl_fall;
  assign byte_done = rise && bit_cnt_q == 4'd7;
  assign ack_fall  = fall && bit_cnt_q == 4'd8;
  assign rx_state  = state_q inside {StAddr, StWrData, StBcastCmd};
  assign rx_byte   = {shift_q[6:0], event_i.sda};
  assign tx_next   = tx_valid_i ? tx_byte_i : ReadFillByte;

  // A dynamic address never aliases the broadcast
  assign bcast_hit = shift_q[6:0] == BroadcastAddr && !is_dyn_i;

  assign load_tx = fall && !event_i.start && !event_i.stop &&
                   ((state_q == StAddrAck && rnw_q) || state_q == StCtrlAck);

  assign addr_o       = shift_q[6:0];
  assign addr_valid_o = state_q == StAddr && byte_done;
  assign dyn_addr_o   = shift_q[6:0];
  assign dyn_load_o   = state_q == StBcastCmd && byte_done && setda_q;
  assign tx_take_o    = load_tx && tx_valid_i;
  assign sda_o        = sda_q;

  always_comb begin
    stream_o.xfer_start = addr_valid_o && match_i && !bcast_hit;
    stream_o.xfer_stop  = (event_i.start || event_i.stop) && active_q;
    stream_o.addr       = shift_q[6:0];
    stream_o.rnw        = event_i.sda;
    stream_o.rx_valid   = state_q == StWrData && byte_done;
    stream_o.rx_byte    = rx_byte;
  end

  // Receive shifts on SCL rise, transmit shifts on SCL fall
  always_ff @(posedge clk_i) begin
    if (load_tx) begin
      shift_q <= tx_next;
    end else if (state_q == StRdData && fall && bit_cnt_q != 4'd8) begin
      shift_q <= {shift_q[6:0], 1'b1};
    end else if (rx_state && rise) begin
      shift_q <= rx_byte;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= StIdle;
      bit_cnt_q  <= '0;
      sda_q      <= 1'b1;
      rnw_q      <= 1'b0;
      bcast_q    <= 1'b0;
      ack_q      <= 1'b0;
      active_q   <= 1'b0;
      cmd_seen_q <= 1'b0;
      setda_q    <= 1'b0;
    end else if (event_i.start) begin
      state_q   <= StAddr;
      bit_cnt_q <= '0;
      sda_q     <= 1'b1;
      active_q  <= 1'b0;
    end else if (event_i.stop) begin
      state_q  <= StIdle;
      sda_q    <= 1'b1;
      active_q <= 1'b0;
    end else begin
      if (rise) begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
      unique case (state_q)
        StAddr: begin
          if (byte_done) begin
            rnw_q      <= event_i.sda;
            bcast_q    <= bcast_hit;
            ack_q      <= match_i && !(bcast_hit && event_i.sda);
            active_q   <= match_i && !bcast_hit;
            cmd_seen_q <= 1'b0;
            setda_q    <= 1'b0;
          end
          if (ack_fall) begin
            state_q <= ack_q ? StAddrAck : StIgnore;
            sda_q   <= !ack_q;
          end
        end
        StAddrAck: begin
          if (fall) begin
            bit_cnt_q <= '0;
            if (rnw_q) begin
              state_q <= StRdData;
              sda_q   <= tx_next[7];
            end else begin
              state_q <= bcast_q ? StBcastCmd : StWrData;
              sda_q   <= 1'b1;
            end
          end
        end
        StWrData, StBcastCmd: begin
          if (byte_done) begin
            if (bcast_q) begin
              // Command byte, then the address byte after a set-address code
              ack_q      <= !cmd_seen_q || setda_q;
              cmd_seen_q <= 1'b1;
              setda_q    <= !cmd_seen_q && rx_byte == CccSetDynAddr;
            end else begin
              ack_q <= !rx_full_i;
            end
          end
          if (ack_fall) begin
            state_q <= StDataAck;
            sda_q   <= !ack_q;
          end
        end
        StDataAck: begin
          if (fall) begin
            state_q   <= bcast_q ? StBcastCmd : StWrData;
            bit_cnt_q <= '0;
            sda_q     <= 1'b1;
          end
        end
        StRdData: begin
          if (ack_fall) begin
            state_q <= StCtrlAck;
            sda_q   <= 1'b1;
          end else if (fall) begin
            sda_q <= shift_q[6];
          end
        end
        StCtrlAck: begin
          // NACK from the controller ends the read
          if (rise && event_i.sda) begin
            state_q <= StIgnore;
          end else if (fall) begin
            state_q   <= StRdData;
            bit_cnt_q <= '0;
            sda_q     <= tx_next[7];
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== hw/addr_match.sv ====
// I3C target address matcher
`timescale 1ns/100ps

module addr_match #(
  parameter logic [6:0] StaticAddr = 7'h22
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [6:0] addr_i,
  input  logic       addr_valid_i,
  input  logic       dyn_load_i,
  input  logic [6:0] dyn_addr_i,
  output logic       match_o,
  output logic       is_dyn_o
);
  import i3c_target_pkg::*;

  logic [6:0] dyn_addr_q;
  logic       dyn_valid_q;
  logic       sta_hit;
  logic       dyn_hit;
  logic       bcast_hit;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dyn_addr_q  <= '0;
      dyn_valid_q <= 1'b0;
    end else if (dyn_load_i) begin
      dyn_addr_q  <= dyn_addr_i;
      dyn_valid_q <= 1'b1;
    end
  end

  assign sta_hit   = addr_i == StaticAddr;
  assign dyn_hit   = dyn_valid_q && addr_i == dyn_addr_q;
  assign bcast_hit = addr_i == BroadcastAddr;

  assign match_o  = addr_valid_i && (sta_hit || dyn_hit || bcast_hit);
  assign is_dyn_o = addr_valid_i && dyn_hit;

endmodule

// ==== hw/sync_queue.sv ====
// Synchronous valid/ready queue
`timescale 1ns/100ps

module sync_queue #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  payload_t wdata_i,
  output logic     rvalid_o,
  input  logic     rready_i,
  output payload_t rdata_o,
  output logic     full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign full_o   = count_q == CntW'(Depth);
  assign wready_o = !full_o;
  assign rvalid_o = count_q != '0;
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

endmodule

// ==== hw/flow_standby.sv ====
// Target byte flow to host queues
`timescale 1ns/100ps

module flow_standby (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  i3c_target_pkg::byte_stream_t stream_i,
  input  logic                         is_dyn_i,
  output logic                         rx_full_o,
  output logic                         rx_wvalid_o,
  output logic [7:0]                   rx_wdata_o,
  input  logic                         rx_wready_i,
  output logic                         desc_wvalid_o,
  output i3c_target_pkg::rx_desc_t     desc_wdata_o,
  input  logic                         tx_rvalid_i,
  input  logic [7:0]                   tx_rdata_i,
  output logic                         tx_rready_o,
  output logic                         tx_valid_o,
  output logic [7:0]                   tx_byte_o,
  input  logic                         tx_take_i
);

  logic [6:0] addr_q;
  logic       rnw_q;
  logic       dyn_q;
  logic [7:0] count_q;
  logic       rx_accept;

  // Same condition the state machine uses for its ACK
  assign rx_full_o = !rx_wready_i;
  assign rx_accept = stream_i.rx_valid && rx_wready_i;

  assign tx_valid_o  = tx_rvalid_i;
  assign tx_byte_o   = tx_rdata_i;
  assign tx_rready_o = tx_take_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_wvalid_o   <= 1'b0;
      desc_wvalid_o <= 1'b0;
      count_q       <= '0;
    end else begin
      rx_wvalid_o   <= rx_accept;
      desc_wvalid_o <= stream_i.xfer_stop && !rnw_q;
      if (stream_i.xfer_start) begin
        count_q <= '0;
      end else if (rx_accept) begin
        count_q <= count_q + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stream_i.xfer_start) begin
      addr_q <= stream_i.addr;
      rnw_q  <= stream_i.rnw;
      dyn_q  <= is_dyn_i;
    end
    if (rx_accept) begin
      rx_wdata_o <= stream_i.rx_byte;
    end
    if (stream_i.xfer_stop) begin
      desc_wdata_o <= '{addr: addr_q, byte_count: count_q, dyn: dyn_q};
    end
  end

endmodule

// ==== hw/controller_standby.sv ====
// I3C standby controller top level
`timescale 1ns/100ps

module controller_standby #(
  parameter logic [6:0]  StaticAddr = 7'h22,
  parameter int unsigned RxDepth    = 4,
  parameter int unsigned TxDepth    = 4,
  parameter int unsigned DescDepth  = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     enable_i,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output logic                     sda_o,
  output logic                     bus_start_o,
  output logic                     bus_stop_o,

  // Host RX data
  output logic                     rx_data_valid_o,
  output logic [7:0]               rx_data_o,
  input  logic                     rx_data_ready_i,

  // Host RX descriptors
  output logic                     rx_desc_valid_o,
  output i3c_target_pkg::rx_desc_t rx_desc_o,
  input  logic                     rx_desc_ready_i,

  // Host TX data
  input  logic                     tx_data_valid_i,
  input  logic [7:0]               tx_data_i,
  output logic                     tx_data_ready_o
);
  import i3c_target_pkg::*;

  bus_event_t   bus_event;
  byte_stream_t stream;
  rx_desc_t     desc_wdata;

  logic [6:0] addr;
  logic       addr_valid;
  logic       match;
  logic       is_dyn;
  logic       dyn_load;
  logic [6:0] dyn_addr;
  logic       rx_full;
  logic       tx_valid;
  logic [7:0] tx_byte;
  logic       tx_take;
  logic       rx_wvalid;
  logic [7:0] rx_wdata;
  logic       rx_wready;
  logic       desc_wvalid;
  logic       tx_rvalid;
  logic [7:0] tx_rdata;
  logic       tx_rready;

  bus_monitor xbus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .enable_i(enable_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .event_o (bus_event)
  );

  assign bus_start_o = bus_event.start;
  assign bus_stop_o  = bus_event.stop;

  target_fsm xtarget_fsm (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .event_i     (bus_event),
    .sda_o       (sda_o),
    .addr_o      (addr),
    .addr_valid_o(addr_valid),
    .match_i     (match),
    .is_dyn_i    (is_dyn),
    .dyn_load_o  (dyn_load),
    .dyn_addr_o  (dyn_addr),
    .stream_o    (stream),
    .rx_full_i   (rx_full),
    .tx_valid_i  (tx_valid),
    .tx_byte_i   (tx_byte),
    .tx_take_o   (tx_take)
  );

  addr_match #(
    .StaticAddr(StaticAddr)
  ) xaddr_match (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .addr_i      (addr),
    .addr_valid_i(addr_valid),
    .dyn_load_i  (dyn_load),
    .dyn_addr_i  (dyn_addr),
    .match_o     (match),
    .is_dyn_o    (is_dyn)
  );

  flow_standby xflow_standby (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stream_i     (stream),
    .is_dyn_i     (is_dyn),
    .rx_full_o    (rx_full),
    .rx_wvalid_o  (rx_wvalid),
    .rx_wdata_o   (rx_wdata),
    .rx_wready_i  (rx_wready),
    .desc_wvalid_o(desc_wvalid),
    .desc_wdata_o (desc_wdata),
    .tx_rvalid_i  (tx_rvalid),
    .tx_rdata_i   (tx_rdata),
    .tx_rready_o  (tx_rready),
    .tx_valid_o   (tx_valid),
    .tx_byte_o    (tx_byte),
    .tx_take_i    (tx_take)
  );

  sync_queue #(
    .payload_t(logic [7:0]),
    .Depth    (RxDepth)
  ) xrx_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wvalid_i(rx_wvalid),
    .wready_o(rx_wready),
    .wdata_i (rx_wdata),
    .rvalid_o(rx_data_valid_o),
    .rready_i(rx_data_ready_i),
    .rdata_o (rx_data_o),
    .full_o  ()
  );

  sync_queue #(
    .payload_t(logic [7:0]),
    .Depth    (TxDepth)
  ) xtx_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wvalid_i(tx_data_valid_i),
    .wready_o(tx_data_ready_o),
    .wdata_i (tx_data_i),
    .rvalid_o(tx_rvalid),
    .rready_i(tx_rready),
    .rdata_o (tx_rdata),
    .full_o  ()
  );

  // A full descriptor queue drops the new descriptor
  sync_queue #(
    .payload_t(rx_desc_t),
    .Depth    (DescDepth)
  ) xdesc_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wvalid_i(desc_wvalid),
    .wready_o(),
    .wdata_i (desc_wdata),
    .rvalid_o(rx_desc_valid_o),
    .rready_i(rx_desc_ready_i),
    .rdata_o (rx_desc_o),
    .full_o  ()
  );

endmodule

// ==== testbench/i3c_bus_tasks.svh ====
// I3C controller bus tasks

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk);
endtask

// One SCL period, low phase first, SDA sampled in the middle of the high phase
task automatic clock_bit(input logic b, output logic seen);
  sda_tb <= b;
  wait_cycles(SclHalf - 2);
  scl <= 1'b1;
  wait_cycles(SclHalf / 2);
  seen = sda_bus;
  wait_cycles(SclHalf / 2);
  scl <= 1'b0;
  wait_cycles(2);
endtask

task automatic start_condition();
  sda_tb <= 1'b1;
  wait_cycles(SclHalf - 2);
  scl <= 1'b1;
  wait_cycles(SclHalf);
  sda_tb <= 1'b0;
  starts_sent++;
  wait_cycles(SclHalf);
  scl <= 1'b0;
  wait_cycles(2);
endtask

// Leaves the bus idle with both lines high
task automatic stop_condition();
  sda_tb <= 1'b0;
  wait_cycles(SclHalf - 2);
  scl <= 1'b1;
  wait_cycles(SclHalf);
  sda_tb <= 1'b1;
  stops_sent++;
  wait_cycles(SclHalf);
endtask

task automatic write_byte(input logic [7:0] b, output logic ack);
  logic seen;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(b[i], seen);
  end
  clock_bit(1'b1, seen);
  ack = !seen;
endtask

task automatic read_byte(input logic nack, output logic [7:0] b);
  logic seen;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(1'b1, seen);
    b[i] = seen;
  end
  clock_bit(nack, seen);
endtask

// ==== testbench/tb_controller_standby.sv ====
// Standby controller testbench
`timescale 1ns/100ps

module tb_controller_standby;
  import i3c_target_pkg::*;

  localparam logic [6:0] StaticAddr  = 7'h22;
  localparam logic [6:0] DynAddr     = 7'h35;
  localparam int         SclHalf     = 8;
  localparam int         Timeout     = 400;
  localparam int         QuietCycles = 40;
  localparam int         NumRows     = 7;

  // One bus transaction and the expected DUT response
  typedef struct packed {
    logic [6:0]      addr;
    logic            rnw;
    logic [3:0]      nbytes;
    logic [7:0][7:0] data;
    logic            addr_ack;
    logic [7:0]      ack_mask;
    logic            desc_exp;
    logic [7:0]      desc_count;
    logic            desc_dyn;
    logic            hold_rx;
    logic [3:0]      tx_fill;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       enable;
  logic       scl = 1'b1;
  logic       sda_tb = 1'b1;
  logic       sda_dut;
  logic       sda_bus;
  logic       bus_start;
  logic       bus_stop;
  logic       rx_data_valid;
  logic [7:0] rx_data;
  logic       rx_data_ready;
  logic       rx_desc_valid;
  rx_desc_t   rx_desc;
  logic       rx_desc_ready;
  logic       tx_data_valid;
  logic [7:0] tx_data;
  logic       tx_data_ready;

  int         seed = 32'h86f5_f667;
  int         errors = 0;
  int         checks = 0;
  int         starts_sent = 0;
  int         stops_sent = 0;
  int         starts_seen = 0;
  int         stops_seen = 0;
  row_t       rows [NumRows];
  logic [7:0] rx_got [$];
  rx_desc_t   desc_got [$];

  // Open-drain wire
  assign sda_bus = sda_tb & sda_dut;

  controller_standby #(
    .StaticAddr(StaticAddr),
    .RxDepth   (4)
  ) controller_standby_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .enable_i       (enable),
    .scl_i          (scl),
    .sda_i          (sda_bus),
    .sda_o          (sda_dut),
    .bus_start_o    (bus_start),
    .bus_stop_o     (bus_stop),
    .rx_data_valid_o(rx_data_valid),
    .rx_data_o      (rx_data),
    .rx_data_ready_i(rx_data_ready),
    .rx_desc_valid_o(rx_desc_valid),
    .rx_desc_o      (rx_desc),
    .rx_desc_ready_i(rx_desc_ready),
    .tx_data_valid_i(tx_data_valid),
    .tx_data_i      (tx_data),
    .tx_data_ready_o(tx_data_ready)
  );

  always #10 clk = ~clk;

  // Host side collects whatever the DUT hands over
  always @(posedge clk) begin
    if (rx_data_valid && rx_data_ready) begin
      rx_got.push_back(rx_data);
    end
    if (rx_desc_valid && rx_desc_ready) begin
      desc_got.push_back(rx_desc);
    end
    if (bus_start) begin
      starts_seen++;
    end
    if (bus_stop) begin
      stops_seen++;
    end
  end

  `include "i3c_bus_tasks.svh"

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  function automatic row_t make_row(input logic [6:0] addr, input logic rnw, input int nbytes,
                                    input logic addr_ack, input logic [7:0] ack_mask,
                                    input logic desc_exp, input int desc_count,
                                    input logic desc_dyn, input logic hold_rx,
                                    input int tx_fill);
    row_t row;
    row.addr       = addr;
    row.rnw        = rnw;
    row.nbytes     = 4'(nbytes);
    row.data       = {$random(seed), $random(seed)};
    row.addr_ack   = addr_ack;
    row.ack_mask   = ack_mask;
    row.desc_exp   = desc_exp;
    row.desc_count = 8'(desc_count);
    row.desc_dyn   = desc_dyn;
    row.hold_rx    = hold_rx;
    row.tx_fill    = 4'(tx_fill);
    return row;
  endfunction

  task automatic preload_tx(input row_t row, input int idx);
    int waited;
    for (int i = 0; i < row.tx_fill; i++) begin
      tx_data_valid <= 1'b1;
      tx_data       <= row.data[i];
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!tx_data_ready && waited < Timeout);
      if (!tx_data_ready) begin
        note_failure($sformatf("row %0d: TX queue never accepted byte %0d", idx, i));
      end
    end
    tx_data_valid <= 1'b0;
  endtask

  task automatic run_row(input int idx);
    row_t       row;
    logic       ack;
    logic [7:0] b;
    logic [7:0] exp_byte;
    logic [7:0] exp_rx [$];
    int         errors_before;
    int         waited;

    row = rows[idx];
    errors_before = errors;
    rx_got.delete();
    desc_got.delete();
    if (row.rnw) begin
      preload_tx(row, idx);
    end
    if (row.hold_rx) begin
      rx_data_ready <= 1'b0;
    end

    start_condition();
    write_byte({row.addr, row.rnw}, ack);
    compare_value(ack, row.addr_ack, "address ACK");
    for (int i = 0; i < row.nbytes; i++) begin
      if (row.rnw) begin
        exp_byte = (i < row.tx_fill) ? row.data[i] : ReadFillByte;
        read_byte(i == row.nbytes - 1, b);
        compare_value(b, exp_byte, "read byte");
      end else begin
        write_byte(row.data[i], ack);
        compare_value(ack, row.ack_mask[i], "data ACK");
        if (row.ack_mask[i] && row.desc_exp) begin
          exp_rx.push_back(row.data[i]);
        end
      end
    end
    stop_condition();

    // Accepted bytes stay queued until the host reads
    if (row.hold_rx) begin
      wait_cycles(QuietCycles);
      compare_value(rx_data_valid, 1'b1, "RX data held while host idle");
      rx_data_ready <= 1'b1;
    end

    waited = 0;
    while ((rx_got.size() < exp_rx.size() || desc_got.size() < row.desc_exp) &&
           waited < Timeout) begin
      @(posedge clk);
      waited++;
    end
    if (rx_got.size() < exp_rx.size() || desc_got.size() < row.desc_exp) begin
      note_failure($sformatf("row %0d: RX data or descriptor did not arrive in %0d cycles",
                             idx, Timeout));
    end
    wait_cycles(QuietCycles);

    compare_value(rx_got.size(), exp_rx.size(), "RX byte count");
    foreach (exp_rx[i]) begin
      if (i < rx_got.size()) begin
        compare_value(rx_got[i], exp_rx[i], "RX byte");
      end
    end
    compare_value(desc_got.size(), row.desc_exp, "descriptor count");
    if (row.desc_exp && desc_got.size() > 0) begin
      compare_value(desc_got[0].addr, row.addr, "descriptor address");
      compare_value(desc_got[0].byte_count, row.desc_count, "descriptor byte count");
      compare_value(desc_got[0].dyn, row.desc_dyn, "descriptor dyn flag");
    end
    $display("row %0d addr %02h %s: %s", idx, row.addr, row.rnw ? "read" : "write",
             (errors == errors_before) ? "ok" : "FAILED");
  endtask

  initial begin
    rst_n         <= 1'b0;
    enable        <= 1'b1;
    rx_data_ready <= 1'b1;
    rx_desc_ready <= 1'b1;
    tx_data_valid <= 1'b0;
    tx_data       <= '0;

    //                 addr           rnw  n  aack mask   desc cnt dyn hold fill
    rows[0] = make_row(StaticAddr,    0,   3, 1,   8'h07, 1,   3,  0,  0,   0);
    rows[1] = make_row(7'h10,         0,   1, 0,   8'h00, 0,   0,  0,  0,   0);
    rows[2] = make_row(StaticAddr,    1,   3, 1,   8'h00, 0,   0,  0,  0,   2);
    rows[3] = make_row(BroadcastAddr, 0,   2, 1,   8'h03, 0,   0,  0,  0,   0);
    rows[4] = make_row(DynAddr,       0,   2, 1,   8'h03, 1,   2,  1,  0,   0);
    rows[5] = make_row(StaticAddr,    0,   2, 1,   8'h03, 1,   2,  0,  0,   0);
    rows[6] = make_row(StaticAddr,    0,   6, 1,   8'h0F, 1,   4,  0,  1,   0);
    // Set-address command, then the new address in the upper seven bits
    rows[3].data[0] = CccSetDynAddr;
    rows[3].data[1] = {DynAddr, 1'b0};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait_cycles(4);

    // Idle state after reset
    compare_value(sda_dut, 1'b1, "SDA after reset");
    compare_value(rx_data_valid, 1'b0, "RX data valid after reset");
    compare_value(rx_desc_valid, 1'b0, "descriptor valid after reset");
    compare_value(tx_data_ready, 1'b1, "TX ready after reset");

    for (int r = 0; r < NumRows; r++) begin
      run_row(r);
    end

    wait_cycles(QuietCycles);
    compare_value(starts_seen, starts_sent, "start pulse count");
    compare_value(stops_seen, stops_sent, "stop pulse count");
    $display("%0d rows, %0d checks, %0d errors", NumRows, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+testbench
common/i3c_target_pkg.sv
hw/bus_monitor.sv
target_fsm/target_fsm.sv
hw/addr_match.sv
hw/sync_queue.sv
hw/flow_standby.sv
hw/controller_standby.sv
testbench/tb_controller_standby.sv
